// ==== logic/icb_bus_params.svh ====
////////////////////
// ICB bus parameters.
// Widths, port count and the address map of the 1-to-4 splitter.
////////////////////
`ifndef ICB_BUS_PARAMS_SVH
`define ICB_BUS_PARAMS_SVH

// Bus widths.
`define ICB_AW 32
`define ICB_DW 32

`define ICB_PORT_NUM 4  // Three mapped ports plus the default.
`define ICB_OUTS_NUM 4  // Outstanding command limit.

////////////////////
// Address map.
// A port owns every address whose bits from LSB upward match its base.
`define ICB_O0_BASE 32'h0000_1000
`define ICB_O0_LSB  12

`define ICB_O1_BASE 32'h0000_2000
`define ICB_O1_LSB  12

`define ICB_O2_BASE 32'h0000_3000
`define ICB_O2_LSB  12

`endif

// ==== logic/icb_bus_pkg.sv ====
////////////////////
// ICB bus types.
// Command and response payloads, port select and per-port responses.
////////////////////
`include "icb_bus_params.svh"

package icb_bus_pkg;

  // Command channel payload.
  typedef struct packed {
    logic [`ICB_AW-1:0]   addr;
    logic                 read;   // High for read.
    logic [`ICB_DW-1:0]   wdata;
    logic [`ICB_DW/8-1:0] wmask;  // Byte enables.
    logic [1:0]           size;
  } icb_cmd_t;

  // Response channel payload.
  typedef struct packed {
    logic               err;
    logic [`ICB_DW-1:0] rdata;
  } icb_rsp_t;

  // One-hot slave port select, bit n is port n.
  typedef logic [`ICB_PORT_NUM-1:0] port_sel_t;

  // Responses of all slave ports.
  typedef icb_rsp_t [`ICB_PORT_NUM-1:0] port_rsp_t;

endpackage

// ==== logic/icb_addr_decode.sv ====
////////////////////
// ICB address decoder.
// Maps a command address and the port enables to a one-hot port.
////////////////////
`timescale 1ns/10ps
`include "icb_bus_params.svh"

module icb_addr_decode
  import icb_bus_pkg::*;
(
  input  logic               clk,
  input  logic               i_rst,
  input  logic [`ICB_AW-1:0] i_addr,
  input  logic [2:0]         i_port_en,
  output port_sel_t          o_sel
);

  localparam int MSB = `ICB_AW - 1;

  localparam logic [`ICB_AW-1:0] O0_BASE = `ICB_O0_BASE;
  localparam logic [`ICB_AW-1:0] O1_BASE = `ICB_O1_BASE;
  localparam logic [`ICB_AW-1:0] O2_BASE = `ICB_O2_BASE;

  logic [2:0] hit;

  assign hit[0] = (i_addr[MSB:`ICB_O0_LSB] == O0_BASE[MSB:`ICB_O0_LSB]);
  assign hit[1] = (i_addr[MSB:`ICB_O1_LSB] == O1_BASE[MSB:`ICB_O1_LSB]);
  assign hit[2] = (i_addr[MSB:`ICB_O2_LSB] == O2_BASE[MSB:`ICB_O2_LSB]);

  always_comb begin
    o_sel[2:0] = hit & i_port_en;   // Disabled ports never claim a command.
    o_sel[3]   = ~|o_sel[2:0];      // Default port.
  end

  ////////////////////
  // Checks.

  // Mapped regions must not overlap.
  a_sel_onehot: assert property (
    @(posedge clk) disable iff (i_rst)
    $onehot(o_sel)
  );

endmodule

// ==== logic/icb_outs_track.sv ====
////////////////////
// ICB outstanding tracker.
// Counts commands awaiting a response and the port they went to.
////////////////////
`timescale 1ns/10ps
`include "icb_bus_params.svh"

module icb_outs_track
  import icb_bus_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,
  input  logic      i_push,
  input  logic      i_pop,
  input  port_sel_t i_push_port,
  output logic      o_outs_empty,
  output logic      o_outs_full,
  output port_sel_t o_outs_port
);

  localparam int CNT_W = $clog2(`ICB_OUTS_NUM + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = `ICB_OUTS_NUM;

  logic [CNT_W-1:0] outs_cnt;
  port_sel_t        outs_port;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      outs_cnt  <= '0;
      outs_port <= '0;
    end else begin
      if (i_push & ~i_pop) begin
        outs_cnt <= outs_cnt + 1'b1;
      end else if (i_pop & ~i_push) begin
        outs_cnt <= outs_cnt - 1'b1;
      end
      // First command of a new group fixes the port.
      if (i_push && (outs_cnt == '0)) begin
        outs_port <= i_push_port;
      end
    end
  end

  assign o_outs_empty = (outs_cnt == '0);
  assign o_outs_full  = (outs_cnt == CNT_MAX);
  assign o_outs_port  = outs_port;

  ////////////////////
  // Checks.

  // A response needs a command issued in an earlier cycle.
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (i_rst)
    i_pop |-> !o_outs_empty
  );

  // The splitter holds commands back at the limit.
  a_no_push_full: assert property (
    @(posedge clk) disable iff (i_rst)
    i_push |-> !o_outs_full
  );

endmodule

// ==== logic/icb_splt.sv ====
////////////////////
// ICB command splitter.
// Routes commands to the decoded port and returns responses in order
// from the port that holds the outstanding group.
////////////////////
`timescale 1ns/10ps

module icb_splt
  import icb_bus_pkg::*;
(
  input  logic      clk,
  input  logic      i_rst,

  // Master side.
  input  logic      i_cmd_valid,
  output logic      o_cmd_ready,
  input  icb_cmd_t  i_cmd,
  output logic      o_rsp_valid,
  input  logic      i_rsp_ready,
  output icb_rsp_t  o_rsp,

  // Decode and tracker state.
  input  port_sel_t i_sel,
  input  port_sel_t i_outs_port,
  input  logic      i_outs_empty,
  input  logic      i_outs_full,

  // Tracker strobes.
  output logic      o_push,
  output logic      o_pop,
  output port_sel_t o_push_port,

  // Slave side.
  output port_sel_t o_port_cmd_valid,
  input  port_sel_t i_port_cmd_ready,
  output icb_cmd_t  o_port_cmd,
  input  port_sel_t i_port_rsp_valid,
  output port_sel_t o_port_rsp_ready,
  input  port_rsp_t i_port_rsp
);

  localparam int PORT_NUM = $bits(port_sel_t);

  logic      same_port;
  logic      cmd_allow;
  port_sel_t rsp_sel;

  ////////////////////
  // Command path.

  // New target only once the previous group has fully answered.
  assign same_port = i_outs_empty | (i_sel == i_outs_port);
  assign cmd_allow = ~i_outs_full & same_port;

  assign o_port_cmd_valid = (i_cmd_valid & cmd_allow) ? i_sel : '0;
  assign o_port_cmd       = i_cmd;   // Broadcast payload.
  assign o_cmd_ready      = cmd_allow & |(i_sel & i_port_cmd_ready);

  assign o_push      = i_cmd_valid & o_cmd_ready;
  assign o_push_port = i_sel;

  ////////////////////
  // Response path.

  assign rsp_sel = i_outs_empty ? '0 : i_outs_port;   // Nothing pending, nothing taken.

  assign o_rsp_valid      = |(rsp_sel & i_port_rsp_valid);
  assign o_port_rsp_ready = i_rsp_ready ? rsp_sel : '0;

  always_comb begin
    o_rsp = '0;
    for (int n = 0; n < PORT_NUM; n++) begin
      if (rsp_sel[n]) begin
        o_rsp = i_port_rsp[n];
      end
    end
  end

  assign o_pop = o_rsp_valid & i_rsp_ready;

  ////////////////////
  // Checks.

  // Decoder select must reach at most one slave.
  a_cmd_valid_onehot0: assert property (
    @(posedge clk) disable iff (i_rst)
    $onehot0(o_port_cmd_valid)
  );

endmodule

// ==== logic/icb_1to4_bus.sv ====
////////////////////
// ICB 1-to-4 bus.
// One master port split over three mapped slaves and a default slave.
////////////////////
`timescale 1ns/10ps
`include "icb_bus_params.svh"

module icb_1to4_bus
  import icb_bus_pkg::*;
(
  input  logic                      clk,
  input  logic                      i_rst,

  // Master side.
  input  logic                      i_cmd_valid,
  output logic                      o_cmd_ready,
  input  icb_cmd_t                  i_cmd,
  output logic                      o_rsp_valid,
  input  logic                      i_rsp_ready,
  output icb_rsp_t                  o_rsp,

  input  logic [`ICB_PORT_NUM-2:0]  i_port_en,   // Enables of the mapped ports.

  // Slave side.
  output port_sel_t                 o_port_cmd_valid,
  input  port_sel_t                 i_port_cmd_ready,
  output icb_cmd_t                  o_port_cmd,
  input  port_sel_t                 i_port_rsp_valid,
  output port_sel_t                 o_port_rsp_ready,
  input  port_rsp_t                 i_port_rsp
);

  port_sel_t sel;
  port_sel_t outs_port;
  port_sel_t push_port;
  logic      outs_empty;
  logic      outs_full;
  logic      push;
  logic      pop;

  icb_addr_decode i_icb_addr_decode (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_addr    (i_cmd.addr),
    .i_port_en (i_port_en),
    .o_sel     (sel)
  );

  icb_outs_track i_icb_outs_track (
    .clk          (clk),
    .i_rst        (i_rst),
    .i_push       (push),
    .i_pop        (pop),
    .i_push_port  (push_port),
    .o_outs_empty (outs_empty),
    .o_outs_full  (outs_full),
    .o_outs_port  (outs_port)
  );

  icb_splt i_icb_splt (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_ready      (o_cmd_ready),
    .i_cmd            (i_cmd),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp            (o_rsp),
    .i_sel            (sel),
    .i_outs_port      (outs_port),
    .i_outs_empty     (outs_empty),
    .i_outs_full      (outs_full),
    .o_push           (push),
    .o_pop            (pop),
    .o_push_port      (push_port),
    .o_port_cmd_valid (o_port_cmd_valid),
    .i_port_cmd_ready (i_port_cmd_ready),
    .o_port_cmd       (o_port_cmd),
    .i_port_rsp_valid (i_port_rsp_valid),
    .o_port_rsp_ready (o_port_rsp_ready),
    .i_port_rsp       (i_port_rsp)
  );

endmodule

// ==== tests/tb_icb_1to4_bus.sv ====
////////////////////
// ICB 1-to-4 bus testbench.
// Drives commands from a vector file, models four slaves and checks
// routing, flow control and in-order responses.
////////////////////
`timescale 1ns/10ps
`include "icb_bus_params.svh"

module tb_icb_1to4_bus
  import icb_bus_pkg::*;
();

  localparam int MAX_TESTS = 64;
  localparam int CLK_HALF  = 4;

  // One line of the vector file.
  typedef struct packed {
    logic [`ICB_AW-1:0] addr;
    logic               read;
    logic [`ICB_DW-1:0] wdata;
    logic [2:0]         port_en;
    logic [1:0]         port;
    logic [7:0]         lat;
    logic [`ICB_DW-1:0] rdata;
    logic               err;
    logic [7:0]         stall;
  } test_t;

  logic      clk = 1'b0;
  logic      i_rst;
  logic      i_cmd_valid;
  logic      o_cmd_ready;
  icb_cmd_t  i_cmd;
  logic      o_rsp_valid;
  logic      i_rsp_ready = 1'b0;
  icb_rsp_t  o_rsp;
  logic [2:0] i_port_en;
  port_sel_t o_port_cmd_valid;
  port_sel_t i_port_cmd_ready = '0;
  icb_cmd_t  o_port_cmd;
  port_sel_t i_port_rsp_valid = '0;
  port_sel_t o_port_rsp_ready;
  port_rsp_t i_port_rsp = '0;

  test_t     tests [MAX_TESTS];
  int        acc_cycle [MAX_TESTS];
  int        slv_fifo [`ICB_PORT_NUM][MAX_TESTS];   // Accepted commands per slave.
  int        slv_wr [`ICB_PORT_NUM];
  int        slv_rd [`ICB_PORT_NUM];
  int        n_tests;
  int        cmd_cnt;
  int        rsp_cnt;
  int        cycle;
  int        outs_cnt;        // Expected tracker state.
  port_sel_t outs_port = '0;
  int        stall_cnt;
  int        full_seen;
  int        block_seen;
  int        stall_seen;
  logic      rsp_ready_nxt = 1'b1;
  logic      hold_valid = 1'b0;
  icb_rsp_t  hold_rsp = '0;
  logic      loaded = 1'b0;
  integer    seed = 32'he1dc19ed;

  icb_1to4_bus i_icb_1to4_bus (
    .clk              (clk),
    .i_rst            (i_rst),
    .i_cmd_valid      (i_cmd_valid),
    .o_cmd_ready      (o_cmd_ready),
    .i_cmd            (i_cmd),
    .o_rsp_valid      (o_rsp_valid),
    .i_rsp_ready      (i_rsp_ready),
    .o_rsp            (o_rsp),
    .i_port_en        (i_port_en),
    .o_port_cmd_valid (o_port_cmd_valid),
    .i_port_cmd_ready (i_port_cmd_ready),
    .o_port_cmd       (o_port_cmd),
    .i_port_rsp_valid (i_port_rsp_valid),
    .o_port_rsp_ready (o_port_rsp_ready),
    .i_port_rsp       (i_port_rsp)
  );

  always #(CLK_HALF) clk = ~clk;

  function automatic port_sel_t port_onehot(input logic [1:0] p);
    port_sel_t s;
    s    = '0;
    s[p] = 1'b1;
    return s;
  endfunction

  function automatic icb_cmd_t build_cmd(input test_t t);
    icb_cmd_t c;
    c.addr  = t.addr;
    c.read  = t.read;
    c.wdata = t.wdata;
    c.wmask = t.read ? '0 : '1;   // Full word writes.
    c.size  = 2'b10;
    return c;
  endfunction

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic load_tests();
    int          fd;
    int          code;
    int          cnt;
    string       line;
    logic [31:0] f [9];
    test_t       t;
    fd = $fopen("tests/icb_1to4_tests.dat", "r");
    if (fd == 0) stop_on_error("Cannot open the test vector file");
    n_tests = 0;
    while (!$feof(fd) && n_tests < MAX_TESTS) begin
      code = $fgets(line, fd);
      if (code > 0) begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
        if (cnt == 9) begin   // Comment lines match nothing.
          t.addr    = f[0];
          t.read    = f[1][0];
          t.wdata   = f[2];
          t.port_en = f[3][2:0];
          t.port    = f[4][1:0];
          t.lat     = f[5][7:0];
          t.rdata   = f[6];
          t.err     = f[7][0];
          t.stall   = f[8][7:0];
          tests[n_tests] = t;
          n_tests++;
        end
      end
    end
    $fclose(fd);
  endtask

  ////////////////////
  // Slave models and master response ready.
  always @(posedge clk) begin
    int idx;
    cycle = cycle + 1;
    #1;
    i_rsp_ready = rsp_ready_nxt;
    for (int p = 0; p < `ICB_PORT_NUM; p++) begin
      i_port_cmd_ready[p] = (($random(seed) & 3) != 0);
      idx = slv_fifo[p][slv_rd[p]];
      if (slv_rd[p] < slv_wr[p] && cycle >= acc_cycle[idx] + int'(tests[idx].lat)) begin
        i_port_rsp_valid[p]    = 1'b1;
        i_port_rsp[p].rdata    = tests[idx].rdata;
        i_port_rsp[p].err      = tests[idx].err;
      end else begin
        i_port_rsp_valid[p]    = 1'b0;
        i_port_rsp[p].rdata    = $random(seed);   // Idle noise.
        i_port_rsp[p].err      = 1'b0;
      end
    end
  end

  ////////////////////
  // Checks at the falling edge.
  always @(negedge clk) begin
    port_sel_t tgt;
    logic      allow;
    int        p;
    if (!i_rst) begin
      if (hold_valid) begin
        assert (o_rsp_valid) else stop_on_error("o_rsp_valid dropped before the master took it");
        assert (o_rsp == hold_rsp)
          else stop_on_error($sformatf("Fail o_rsp: got %h expected %h", o_rsp, hold_rsp));
      end
      if (o_rsp_valid) begin
        assert (rsp_cnt < cmd_cnt) else stop_on_error("Response returned with nothing outstanding");
      end
      // Only the port of the oldest command sees the master's ready.
      tgt = (rsp_cnt < cmd_cnt && i_rsp_ready) ? port_onehot(tests[rsp_cnt].port) : '0;
      assert (o_port_rsp_ready == tgt) else stop_on_error(
        $sformatf("Fail o_port_rsp_ready: got %h expected %h", o_port_rsp_ready, tgt));
      if (o_rsp_valid && !i_rsp_ready) begin
        stall_cnt++;
        stall_seen++;
      end
      if (i_cmd_valid) begin
        tgt   = port_onehot(tests[cmd_cnt].port);
        allow = (outs_cnt < `ICB_OUTS_NUM) && (outs_cnt == 0 || outs_port == tgt);
        if (outs_cnt == `ICB_OUTS_NUM) full_seen++;
        else if (!allow) block_seen++;
        if (allow) begin
          assert (o_port_cmd_valid == tgt) else stop_on_error(
            $sformatf("Fail o_port_cmd_valid: got %h expected %h", o_port_cmd_valid, tgt));
          assert (o_cmd_ready == |(tgt & i_port_cmd_ready)) else stop_on_error(
            $sformatf("Fail o_cmd_ready: got %h expected %h", o_cmd_ready,
                      |(tgt & i_port_cmd_ready)));
        end else begin
          assert (o_port_cmd_valid == '0) else stop_on_error(
            $sformatf("Fail o_port_cmd_valid: got %h expected 0", o_port_cmd_valid));
          assert (!o_cmd_ready) else stop_on_error("Fail o_cmd_ready: got 1 expected 0");
        end
      end else begin
        assert (o_port_cmd_valid == '0) else stop_on_error(
          $sformatf("Fail o_port_cmd_valid: got %h expected 0", o_port_cmd_valid));
      end
      // Responses leave before this cycle's command is counted.
      if (o_rsp_valid && i_rsp_ready) begin
        assert (o_rsp.rdata == tests[rsp_cnt].rdata) else stop_on_error($sformatf(
          "Fail o_rsp.rdata: got %h expected %h", o_rsp.rdata, tests[rsp_cnt].rdata));
        assert (o_rsp.err == tests[rsp_cnt].err) else stop_on_error(
          $sformatf("Fail o_rsp.err: got %h expected %h", o_rsp.err, tests[rsp_cnt].err));
        p = int'(tests[rsp_cnt].port);
        slv_rd[p]++;
        rsp_cnt++;
        stall_cnt = 0;
        outs_cnt--;
      end
      if (i_cmd_valid && o_cmd_ready) begin
        assert (o_port_cmd == i_cmd) else stop_on_error(
          $sformatf("Fail o_port_cmd: got %h expected %h", o_port_cmd, i_cmd));
        p = int'(tests[cmd_cnt].port);
        slv_fifo[p][slv_wr[p]] = cmd_cnt;
        slv_wr[p]++;
        acc_cycle[cmd_cnt] = cycle;
        if (outs_cnt == 0) outs_port = port_onehot(tests[cmd_cnt].port);
        outs_cnt++;
        cmd_cnt++;
      end
      hold_valid    = o_rsp_valid && !i_rsp_ready;
      hold_rsp      = o_rsp;
      rsp_ready_nxt = (rsp_cnt >= cmd_cnt) || (stall_cnt >= int'(tests[rsp_cnt].stall));
    end
  end

  ////////////////////
  // Watchdog.
  initial begin
    wait (loaded);
    repeat (n_tests * 64) @(posedge clk);
    $display("Watchdog timeout, responses still missing after %0d cycles", n_tests * 64);
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    i_rst       = 1'b1;
    i_cmd_valid = 1'b0;
    i_cmd       = '0;
    i_port_en   = '0;
    load_tests();
    if (n_tests == 0) stop_on_error("The test vector file holds no transactions");
    loaded = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    i_rst = 1'b0;
    for (int i = 0; i < n_tests; i++) begin
      i_cmd       = build_cmd(tests[i]);
      i_port_en   = tests[i].port_en;
      i_cmd_valid = 1'b1;
      do @(posedge clk); while (cmd_cnt <= i);
      #1;
    end
    i_cmd_valid = 1'b0;
    while (rsp_cnt < n_tests) @(posedge clk);
    if (full_seen > 0 && block_seen > 0 && stall_seen > 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      stop_on_error("The vectors never filled the tracker, switched target or stalled");
    end
  end

endmodule

// ==== tests/icb_1to4_tests.dat ====
// ICB 1-to-4 bus test vectors, all fields in hex.
// addr read wdata port_en exp_port rsp_latency rsp_rdata rsp_err rsp_stall
// Basic decode, all mapped ports enabled.
00001000 0 11110000 7 0 01 00000000 0 00
00001004 1 00000000 7 0 02 a0a01004 0 00
00001ffc 1 00000000 7 0 01 a0a01ffc 0 01
00002000 0 22220000 7 1 01 00000000 0 00
00002ffc 1 00000000 7 1 03 b0b02ffc 0 01
00003000 0 33330000 7 2 02 00000000 0 00
00003abc 1 00000000 7 2 01 c0c03abc 1 00
// Unmapped addresses go to the default port.
00004000 1 00000000 7 3 01 d0d04000 0 00
00000ffc 1 00000000 7 3 02 d0d00ffc 0 02
80001000 0 44440000 7 3 01 00000000 1 00
ffffffff 1 00000000 7 3 01 d0dfffff 0 00
// Disabled ports fall through to the default.
00001010 1 00000000 6 3 01 e0e01010 0 00
00002020 1 00000000 5 3 02 e0e02020 0 00
00003030 1 00000000 3 3 01 e0e03030 0 00
00003030 1 00000000 4 2 01 f0f03030 0 00
00001010 1 00000000 1 0 01 f0f01010 0 00
// Outstanding limit on port 1 with long latencies.
00002100 1 00000000 7 1 20 01012100 0 00
00002104 1 00000000 7 1 1e 01012104 0 00
00002108 0 55550000 7 1 1c 00000000 0 02
0000210c 1 00000000 7 1 1a 0101210c 1 00
00002110 1 00000000 7 1 01 01012110 0 00
00002114 1 00000000 7 1 01 01012114 0 03
// Target switches while responses are pending, with back-pressure.
00001100 1 00000000 7 0 08 02021100 0 03
00001104 0 66660000 7 0 04 00000000 0 00
00003100 1 00000000 7 2 02 03033100 0 02
00003104 1 00000000 7 2 01 03033104 1 00
00000100 1 00000000 7 3 03 04040100 0 04
00002200 1 00000000 7 1 05 05052200 1 01
00001200 0 77770000 7 0 01 00000000 0 00
00002200 1 00000000 7 1 01 05052200 0 00
00003200 0 88880000 7 2 06 00000000 0 02
00001300 1 00000000 7 0 01 06061300 0 00
00001304 1 00000000 7 0 01 06061304 0 00
00001308 1 00000000 7 0 01 06061308 0 05

// ==== files.f ====
+incdir+logic
logic/icb_bus_pkg.sv
logic/icb_addr_decode.sv
logic/icb_outs_track.sv
logic/icb_splt.sv
logic/icb_1to4_bus.sv
tests/tb_icb_1to4_bus.sv

// ==== Makefile ====
# Verilator flow for the ICB 1-to-4 bus.
# Any variable below can be set on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_icb_1to4_bus
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
LINTFLAGS ?= --timing
PASS_MSG  ?= Testbench passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed, log in $(LOG)"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
